//--- Bender.yml
# Uncore IO subsystem: arbiter, thread control and performance counters

package:
  name: io_subsystem

sources:
  # Shared packages, compiled first
  - files:
      - common/uncore_config_pkg.sv
      - common/io_types_pkg.sv

  # RTL, top level last
  - files:
      - rtl/io_interconnect.sv
      - rtl/thread_control.sv
      - rtl/performance_counters.sv
      - rtl/io_subsystem.sv

  # Testbench
  - target: simulation
    files:
      - sim/io_subsystem_tb.sv

//--- common/io_types_pkg.sv
/*
 * IO types
 * Request and response packets exchanged between the cores and the
 * interconnect, the shared IO bus request and the IO opcode.
 */
`default_nettype none

package io_types_pkg;

    import uncore_config_pkg::*;

    typedef enum logic
    {
        IO_LOAD,
        IO_STORE
    } io_op_t;

    typedef logic [CORE_ID_WIDTH-1:0] core_id_t;
    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // Core to interconnect
    typedef struct packed
    {
        io_op_t                   op;
        thread_idx_t              thread_idx;
        logic [IO_ADDR_WIDTH-1:0] address;
        logic [IO_DATA_WIDTH-1:0] data;
    } ioreq_packet_t;

    // Interconnect to all cores, matched by core id and thread
    typedef struct packed
    {
        core_id_t                 core_id;
        thread_idx_t              thread_idx;
        logic [IO_DATA_WIDTH-1:0] read_value;
    } iorsp_packet_t;

    // One strobe at most per cycle
    typedef struct packed
    {
        logic                     write_en;
        logic                     read_en;
        logic [IO_ADDR_WIDTH-1:0] address;
        logic [IO_DATA_WIDTH-1:0] write_data;
    } io_bus_req_t;

endpackage

`default_nettype wire

//--- common/uncore_config_pkg.sv
/*
 * Uncore configuration
 * Field widths, IO register addresses and the limits that bound the
 * top-level parameters of the IO subsystem.
 */
`default_nettype none

package uncore_config_pkg;

    // Field widths
    localparam int CORE_ID_WIDTH = 2;
    localparam int THREAD_IDX_WIDTH = 2;
    localparam int IO_ADDR_WIDTH = 32;
    localparam int IO_DATA_WIDTH = 32;

    // Limits, at most 1 << CORE_ID_WIDTH cores
    localparam int MAX_THREADS = 32;
    localparam int MAX_PERF_EVENTS = 8;

    // Register map
    localparam logic [IO_ADDR_WIDTH-1:0] THREAD_RESUME_ADDR = 32'h100;
    localparam logic [IO_ADDR_WIDTH-1:0] THREAD_HALT_ADDR = 32'h104;
    localparam logic [IO_ADDR_WIDTH-1:0] PERF_REGION_BASE = 32'h200;
    localparam logic [IO_ADDR_WIDTH-1:0] PERF_REGION_LIMIT = 32'h21f;

    // True for addresses served by the performance counters
    function automatic logic in_perf_region(input logic [IO_ADDR_WIDTH-1:0] address);
        return (address >= PERF_REGION_BASE) && (address <= PERF_REGION_LIMIT);
    endfunction

endpackage

`default_nettype wire

//--- rtl/io_interconnect.sv
/*
 * IO interconnect
 * Round-robin arbiter that grants one core IO request per cycle, puts the
 * granted request on the shared IO bus and broadcasts the response.
 */
`timescale 1ns/1ps
`default_nettype none

module io_interconnect
    import uncore_config_pkg::*, io_types_pkg::*;
#(
    parameter int NUM_CORES = 4
)
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [NUM_CORES-1:0]     ior_request_valid,
    input  wire ioreq_packet_t            ior_request [NUM_CORES],
    input  wire logic [IO_DATA_WIDTH-1:0] read_data,
    output logic [NUM_CORES-1:0]          ii_ready,
    output io_bus_req_t                   bus_req,
    output logic                          ii_response_valid,
    output iorsp_packet_t                 ii_response
);

    logic [NUM_CORES-1:0]     pending;
    logic                     grant_found;
    core_id_t                 next_core;
    logic [NUM_CORES-1:0]     grant_onehot;
    core_id_t                 grant_core;
    ioreq_packet_t            granted_req;
    logic                     bus_write_en;
    logic                     bus_read_en;
    logic [IO_ADDR_WIDTH-1:0] bus_address;
    logic [IO_DATA_WIDTH-1:0] bus_write_data;
    core_id_t                 bus_core;
    thread_idx_t              bus_thread;
    logic                     rsp_is_load;
    core_id_t                 rsp_core;
    thread_idx_t              rsp_thread;

    // A core being granted this cycle has already been served
    assign pending = ior_request_valid & ~ii_ready;

    // Search cyclically, starting after the last granted core
    always_comb
    begin
        int candidate;
        grant_found = 1'b0;
        next_core = grant_core;
        for (int offset = 1; offset <= NUM_CORES; offset++)
        begin
            candidate = (int'(grant_core) + offset) % NUM_CORES;
            if (!grant_found && pending[candidate])
            begin
                grant_found = 1'b1;
                next_core = core_id_t'(candidate);
            end
        end
    end

    assign grant_onehot = grant_found ? (NUM_CORES'(1) << next_core) : '0;

    // Grant stage, grant_core doubles as the round-robin pointer
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ii_ready <= '0;
            grant_core <= core_id_t'(NUM_CORES - 1);
        end
        else
        begin
            ii_ready <= grant_onehot;
            if (grant_found)
                grant_core <= next_core;
        end
    end

    assign granted_req = ior_request[grant_core];

    // Bus stage
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            bus_write_en <= 1'b0;
            bus_read_en <= 1'b0;
        end
        else
        begin
            bus_write_en <= (|ii_ready) && (granted_req.op == IO_STORE);
            bus_read_en <= (|ii_ready) && (granted_req.op == IO_LOAD);
        end
    end

    always_ff @(posedge clk)
    begin
        if (|ii_ready)
        begin
            bus_address <= granted_req.address;
            bus_write_data <= granted_req.data;
            bus_core <= grant_core;
            bus_thread <= granted_req.thread_idx;
        end
    end

    assign bus_req.write_en = bus_write_en;
    assign bus_req.read_en = bus_read_en;
    assign bus_req.address = bus_address;
    assign bus_req.write_data = bus_write_data;

    // Response stage
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ii_response_valid <= 1'b0;
            rsp_is_load <= 1'b0;
        end
        else
        begin
            ii_response_valid <= bus_write_en || bus_read_en;
            rsp_is_load <= bus_read_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_write_en || bus_read_en)
        begin
            rsp_core <= bus_core;
            rsp_thread <= bus_thread;
        end
    end

    // Read data arrives aligned with the response cycle
    assign ii_response.core_id = rsp_core;
    assign ii_response.thread_idx = rsp_thread;
    assign ii_response.read_value = rsp_is_load ? read_data : '0;

endmodule

`default_nettype wire

//--- rtl/io_subsystem.sv
/*
 * IO subsystem
 * Uncore of the multi-core processor: arbitrates core IO requests onto the
 * external IO bus, holds the thread-enable register and the performance
 * counters, and steers read data back from the right source.
 */
`timescale 1ns/1ps
`default_nettype none

module io_subsystem
    import uncore_config_pkg::*, io_types_pkg::*;
#(
    parameter int NUM_CORES = 4,
    parameter int THREADS_PER_CORE = 4,
    parameter int NUM_PERF_EVENTS = 8
)
(
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [NUM_CORES-1:0]              ior_request_valid,
    input  wire ioreq_packet_t                     ior_request [NUM_CORES],
    input  wire logic [IO_DATA_WIDTH-1:0]          io_read_data,
    input  wire logic [NUM_PERF_EVENTS-1:0]        perf_events,
    output logic [NUM_CORES-1:0]                   ii_ready,
    output logic                                   ii_response_valid,
    output iorsp_packet_t                          ii_response,
    output io_bus_req_t                            io_bus,
    output logic [NUM_CORES*THREADS_PER_CORE-1:0]  thread_en,
    output logic                                   processor_halt
);

    typedef enum logic
    {
        IO_PERF_COUNTERS,
        IO_ARBITER
    } read_source_t;

    io_bus_req_t              bus_req;
    read_source_t             read_source;
    logic [IO_DATA_WIDTH-1:0] perf_read_data;
    logic [IO_DATA_WIDTH-1:0] ext_read_data;
    logic [IO_DATA_WIDTH-1:0] read_data;

    io_interconnect #(
        .NUM_CORES(NUM_CORES)
    ) u_io_interconnect (
        .clk              (clk),
        .reset            (reset),
        .ior_request_valid(ior_request_valid),
        .ior_request      (ior_request),
        .read_data        (read_data),
        .ii_ready         (ii_ready),
        .bus_req          (bus_req),
        .ii_response_valid(ii_response_valid),
        .ii_response      (ii_response)
    );

    thread_control #(
        .NUM_CORES       (NUM_CORES),
        .THREADS_PER_CORE(THREADS_PER_CORE)
    ) u_thread_control (
        .clk           (clk),
        .reset         (reset),
        .bus_req       (bus_req),
        .thread_en     (thread_en),
        .processor_halt(processor_halt)
    );

    performance_counters #(
        .NUM_PERF_EVENTS(NUM_PERF_EVENTS)
    ) u_performance_counters (
        .clk        (clk),
        .reset      (reset),
        .perf_events(perf_events),
        .bus_req    (bus_req),
        .read_data  (perf_read_data)
    );

    // Counter accesses also go out on the external bus
    assign io_bus = bus_req;

    // Source of the data returned in the cycle after the strobe
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_source <= IO_ARBITER;
        else if (in_perf_region(bus_req.address))
            read_source <= IO_PERF_COUNTERS;
        else
            read_source <= IO_ARBITER;
    end

    // Device answers during the strobe cycle
    always_ff @(posedge clk)
    begin
        if (bus_req.read_en)
            ext_read_data <= io_read_data;
    end

    always_comb
    begin
        if (read_source == IO_PERF_COUNTERS)
            read_data = perf_read_data;
        else
            read_data = ext_read_data;
    end

endmodule

`default_nettype wire

//--- rtl/performance_counters.sv
/*
 * Performance counters
 * One 32-bit counter per event line, read back as consecutive words in the
 * counter region of the IO bus.
 */
`timescale 1ns/1ps
`default_nettype none

module performance_counters
    import uncore_config_pkg::*, io_types_pkg::*;
#(
    parameter int NUM_PERF_EVENTS = 8
)
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [NUM_PERF_EVENTS-1:0] perf_events,
    input  wire io_bus_req_t                bus_req,
    output logic [IO_DATA_WIDTH-1:0]        read_data
);

    localparam int INDEX_WIDTH = $clog2(MAX_PERF_EVENTS);

    logic [IO_DATA_WIDTH-1:0] event_count [NUM_PERF_EVENTS];
    logic [INDEX_WIDTH-1:0]   read_index;
    logic                     counter_read;

    // Word index inside the counter region
    assign read_index = bus_req.address[INDEX_WIDTH+1:2];
    assign counter_read = bus_req.read_en && in_perf_region(bus_req.address);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_PERF_EVENTS; i++)
                event_count[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_PERF_EVENTS; i++)
            begin
                if (perf_events[i])
                    event_count[i] <= event_count[i] + 1'b1;
            end
        end
    end

    // Captures the count before this edge's increment
    always_ff @(posedge clk)
    begin
        if (counter_read)
        begin
            if (int'(read_index) < NUM_PERF_EVENTS)
                read_data <= event_count[read_index];
            else
                read_data <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/thread_control.sv
/*
 * Thread control
 * Thread-enable mask set and cleared by IO bus writes, and the processor
 * halt flag that goes high once every thread is disabled.
 */
`timescale 1ns/1ps
`default_nettype none

module thread_control
    import uncore_config_pkg::*, io_types_pkg::*;
#(
    parameter int NUM_CORES = 4,
    parameter int THREADS_PER_CORE = 4
)
(
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire io_bus_req_t                       bus_req,
    output logic [NUM_CORES*THREADS_PER_CORE-1:0]  thread_en,
    output logic                                   processor_halt
);

    localparam int TOTAL_THREADS = NUM_CORES * THREADS_PER_CORE;

    logic [MAX_THREADS-1:0] thread_mask;

    assign thread_mask = bus_req.write_data;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            thread_en <= TOTAL_THREADS'(1);
        else if (bus_req.write_en)
        begin
            case (bus_req.address)
                THREAD_RESUME_ADDR:
                    thread_en <= thread_en | thread_mask[TOTAL_THREADS-1:0];
                THREAD_HALT_ADDR:
                    thread_en <= thread_en & ~thread_mask[TOTAL_THREADS-1:0];
                default:
                    thread_en <= thread_en;
            endcase
        end
    end

    assign processor_halt = (thread_en == '0);

endmodule

`default_nettype wire

//--- sim/io_subsystem_tb.sv
/*
 * IO subsystem testbench
 * Random core IO traffic from an LFSR, an external device model and a
 * cycle-level reference model of arbitration, thread mask and counters.
 */
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_tb
    import uncore_config_pkg::*, io_types_pkg::*;
();

    localparam int NUM_CORES = 4;
    localparam int THREADS_PER_CORE = 4;
    localparam int NUM_PERF_EVENTS = 8;
    localparam int TOTAL_THREADS = NUM_CORES * THREADS_PER_CORE;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 8;
    localparam int NUM_TRANSACTIONS = 2000;
    localparam int WATCHDOG_CYCLES = 20 * NUM_TRANSACTIONS * NUM_CORES;
    localparam logic [15:0] LFSR_SEED = 16'd23714;
    localparam logic [31:0] DEVICE_PATTERN = 32'ha5a5a5a5;

    logic                               clk;
    logic                               reset;
    logic [NUM_CORES-1:0]               core_valid;
    ioreq_packet_t                      core_req [NUM_CORES];
    logic [IO_DATA_WIDTH-1:0]           io_read_data;
    logic [NUM_PERF_EVENTS-1:0]         perf_events;
    logic [NUM_CORES-1:0]               ii_ready;
    logic                               ii_response_valid;
    iorsp_packet_t                      ii_response;
    io_bus_req_t                        io_bus;
    logic [TOTAL_THREADS-1:0]           thread_en;
    logic                               processor_halt;

    // Reference model state after the latest rising edge
    logic [NUM_CORES-1:0]     model_ready;
    int                       model_ptr;
    io_bus_req_t              model_bus;
    core_id_t                 model_bus_core;
    thread_idx_t              model_bus_thread;
    logic                     model_rsp_valid;
    iorsp_packet_t            model_rsp;
    logic [TOTAL_THREADS-1:0] model_thread_en;
    logic [31:0]              model_count [NUM_PERF_EVENTS];

    logic [15:0]          lfsr_state;
    logic [NUM_CORES-1:0] busy;
    int                   issued;
    int                   rsp_count;
    int                   halt_cycles;
    int                   resumed_cycles;

    io_subsystem #(
        .NUM_CORES       (NUM_CORES),
        .THREADS_PER_CORE(THREADS_PER_CORE),
        .NUM_PERF_EVENTS (NUM_PERF_EVENTS)
    ) u_io_subsystem (
        .clk              (clk),
        .reset            (reset),
        .ior_request_valid(core_valid),
        .ior_request      (core_req),
        .io_read_data     (io_read_data),
        .perf_events      (perf_events),
        .ii_ready         (ii_ready),
        .ii_response_valid(ii_response_valid),
        .ii_response      (ii_response),
        .io_bus           (io_bus),
        .thread_en        (thread_en),
        .processor_halt   (processor_halt)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR on taps 16 14 13 11
    // One step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Mix of thread registers, counter words and external words
    function automatic ioreq_packet_t random_request();
        ioreq_packet_t req;
        logic [1:0]    kind;
        req.op = random_bits(1) ? IO_STORE : IO_LOAD;
        req.thread_idx = thread_idx_t'(random_bits(2));
        kind = 2'(random_bits(2));
        case (kind)
            2'd0:
            begin
                req.address = random_bits(1) ? THREAD_HALT_ADDR : THREAD_RESUME_ADDR;
                case (2'(random_bits(2)))
                    2'd0: req.data = '1;
                    2'd1: req.data = 32'd1 << random_bits(4);
                    default: req.data = random_bits(16);
                endcase
            end
            2'd1:
            begin
                req.address = PERF_REGION_BASE + (random_bits(3) << 2);
                req.data = random_bits(32);
            end
            default:
            begin
                req.address = random_bits(30) << 2;
                req.data = random_bits(32);
            end
        endcase
        return req;
    endfunction

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_ready(input logic [NUM_CORES-1:0] got,
                               input logic [NUM_CORES-1:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] t=%0t ii_ready %b, expected %b", $time, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_bus(input io_bus_req_t got, input io_bus_req_t expected);
        if (got.write_en !== expected.write_en || got.read_en !== expected.read_en)
        begin
            $display("[FAIL] t=%0t bus strobes we=%b re=%b, expected we=%b re=%b", $time,
                     got.write_en, got.read_en, expected.write_en, expected.read_en);
            stop_on_failure();
        end
        else if ((expected.write_en || expected.read_en) &&
                 (got.address !== expected.address || got.write_data !== expected.write_data))
        begin
            $display("[FAIL] t=%0t bus addr %h data %h, expected addr %h data %h", $time,
                     got.address, got.write_data, expected.address, expected.write_data);
            stop_on_failure();
        end
    endtask

    task automatic check_response(input logic got_valid, input iorsp_packet_t got,
                                  input logic expected_valid, input iorsp_packet_t expected);
        if (got_valid !== expected_valid)
        begin
            $display("[FAIL] t=%0t response valid %b, expected %b", $time,
                     got_valid, expected_valid);
            stop_on_failure();
        end
        else if (expected_valid && got !== expected)
        begin
            $display("[FAIL] t=%0t response core %0d thread %0d value %h, expected %0d %0d %h",
                     $time, got.core_id, got.thread_idx, got.read_value,
                     expected.core_id, expected.thread_idx, expected.read_value);
            stop_on_failure();
        end
    endtask

    task automatic check_threads(input logic [TOTAL_THREADS-1:0] got_en, input logic got_halt,
                                 input logic [TOTAL_THREADS-1:0] expected_en,
                                 input logic expected_halt);
        if (got_en !== expected_en || got_halt !== expected_halt)
        begin
            $display("[FAIL] t=%0t thread_en %h halt %b, expected %h halt %b", $time,
                     got_en, got_halt, expected_en, expected_halt);
            stop_on_failure();
        end
    endtask

    // One rising edge of the model on the inputs held over the last cycle
    task automatic step_model();
        logic [NUM_CORES-1:0] pending;
        logic                 found;
        int                   candidate;
        int                   idx;
        ioreq_packet_t        granted;
        // Response to the strobe of the last cycle
        model_rsp_valid = model_bus.write_en || model_bus.read_en;
        model_rsp.core_id = model_bus_core;
        model_rsp.thread_idx = model_bus_thread;
        model_rsp.read_value = '0;
        if (model_bus.read_en)
        begin
            if (model_bus.address >= PERF_REGION_BASE && model_bus.address <= PERF_REGION_LIMIT)
            begin
                idx = int'((model_bus.address - PERF_REGION_BASE) >> 2);
                model_rsp.read_value = (idx < NUM_PERF_EVENTS) ? model_count[idx] : '0;
            end
            else
                model_rsp.read_value = model_bus.address ^ DEVICE_PATTERN;
        end
        if (model_bus.write_en && model_bus.address == THREAD_RESUME_ADDR)
            model_thread_en = model_thread_en | model_bus.write_data[TOTAL_THREADS-1:0];
        if (model_bus.write_en && model_bus.address == THREAD_HALT_ADDR)
            model_thread_en = model_thread_en & ~model_bus.write_data[TOTAL_THREADS-1:0];
        // Counts move only after the read above has taken its value
        for (int e = 0; e < NUM_PERF_EVENTS; e++)
        begin
            if (perf_events[e])
                model_count[e] = model_count[e] + 1;
        end
        model_bus.write_en = 1'b0;
        model_bus.read_en = 1'b0;
        if (|model_ready)
        begin
            granted = core_req[model_ptr];
            model_bus.write_en = (granted.op == IO_STORE);
            model_bus.read_en = (granted.op == IO_LOAD);
            model_bus.address = granted.address;
            model_bus.write_data = granted.data;
            model_bus_core = core_id_t'(model_ptr);
            model_bus_thread = granted.thread_idx;
        end
        // Round robin after the last granted core
        pending = core_valid & ~model_ready;
        found = 1'b0;
        model_ready = '0;
        for (int offset = 1; offset <= NUM_CORES; offset++)
        begin
            candidate = (model_ptr + offset) % NUM_CORES;
            if (!found && pending[candidate])
            begin
                found = 1'b1;
                model_ready[candidate] = 1'b1;
                model_ptr = candidate;
            end
        end
    endtask

    task automatic compare_outputs();
        check_ready(ii_ready, model_ready);
        check_bus(io_bus, model_bus);
        check_response(ii_response_valid, ii_response, model_rsp_valid, model_rsp);
        check_threads(thread_en, processor_halt, model_thread_en, model_thread_en == '0);
        if (model_rsp_valid)
            rsp_count++;
        // Only a resume can bring the mask back from all zero
        if (model_thread_en == '0)
            halt_cycles++;
        else if (halt_cycles > 0)
            resumed_cycles++;
    endtask

    // External device answers within the strobe cycle
    task automatic drive_device();
        if (io_bus.read_en)
            io_read_data = io_bus.address ^ DEVICE_PATTERN;
        else
            io_read_data = random_bits(32);
    endtask

    task automatic drive_cores();
        for (int i = 0; i < NUM_CORES; i++)
        begin
            // A granted request stays up through the accepting edge
            if (model_ready[i])
                busy[i] = 1'b0;
            else if (!busy[i])
            begin
                if (issued < NUM_TRANSACTIONS && 2'(random_bits(2)) != 2'd0)
                begin
                    core_req[i] = random_request();
                    core_valid[i] = 1'b1;
                    busy[i] = 1'b1;
                    issued++;
                end
                else
                    core_valid[i] = 1'b0;
            end
        end
    endtask

    initial
    begin
        lfsr_state = LFSR_SEED;
        reset = 1'b1;
        core_valid = '0;
        for (int i = 0; i < NUM_CORES; i++)
            core_req[i] = '0;
        io_read_data = '0;
        perf_events = '0;
        busy = '0;
        issued = 0;
        rsp_count = 0;
        halt_cycles = 0;
        resumed_cycles = 0;
        model_ready = '0;
        model_ptr = NUM_CORES - 1;
        model_bus = '0;
        model_bus_core = '0;
        model_bus_thread = '0;
        model_rsp_valid = 1'b0;
        model_rsp = '0;
        model_thread_en = TOTAL_THREADS'(1);
        for (int e = 0; e < NUM_PERF_EVENTS; e++)
            model_count[e] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet bus with no requests
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            step_model();
            compare_outputs();
            drive_device();
            perf_events = NUM_PERF_EVENTS'(random_bits(NUM_PERF_EVENTS));
        end

        while (issued < NUM_TRANSACTIONS || busy != '0 || rsp_count < issued)
        begin
            @(negedge clk);
            step_model();
            compare_outputs();
            drive_device();
            drive_cores();
            perf_events = NUM_PERF_EVENTS'(random_bits(NUM_PERF_EVENTS));
        end

        repeat (4)
        begin
            @(negedge clk);
            step_model();
            compare_outputs();
            drive_device();
        end

        $display("Transactions %0d, responses %0d, halted cycles %0d, resumed cycles %0d",
                 issued, rsp_count, halt_cycles, resumed_cycles);
        if (halt_cycles == 0 || resumed_cycles == 0)
        begin
            $display("The stimulus never halted all threads and then resumed one");
            stop_on_failure();
        end
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

endmodule

`default_nettype wire

//--- verilog.f
common/uncore_config_pkg.sv
common/io_types_pkg.sv
rtl/io_interconnect.sv
rtl/thread_control.sv
rtl/performance_counters.sv
rtl/io_subsystem.sv
sim/io_subsystem_tb.sv
